/* project.f */
+incdir+src
src/oq_pkg.sv
src/oq_pkt_store.sv
src/oq_enqueue.sv
src/oq_pifo_calendar.sv
src/oq_dequeue.sv
src/oq_top.sv
bench/tb_oq.sv

/* Makefile */
VERILATOR  := verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing
TOP        := tb_oq
RTL_TOP    := oq_top
FILELIST   := project.f
PASS_MSG   := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf obj_dir

/* bench/tb_oq.sv */
`timescale 1ns/1ps
`include "oq_consts.svh"

module tb_oq
    import oq_pkg::*;
();

    localparam int CLK_NS      = 20;
    localparam int BATCH_PKTS  = 6;
    localparam int STREAM_PKTS = 40;
    // output and skid registers hold two plug beats whose words are already free
    localparam int HELD_BEATS  = 2;
    localparam int MAX_PKTS    = 1 + (1 + BATCH_PKTS) + (`OQ_PIFO_DEPTH + 2) + STREAM_PKTS;
    // 200 cycles per beat at most, plus reset and settling margin
    localparam longint WATCHDOG_NS =
        (longint'(MAX_PKTS) * `OQ_MAX_PKT_WORDS * 200 + 500) * longint'(CLK_NS);

    typedef struct packed {
        oq_beat_t              beat;
        logic [`OQ_RANK_W-1:0] rank;
    } exp_beat_t;

    logic                  axis_aclk;
    logic                  axis_resetn;
    logic [`OQ_DATA_W-1:0] s_axis_tdata;
    logic [`OQ_KEEP_W-1:0] s_axis_tkeep;
    logic                  s_axis_tlast;
    logic [`OQ_RANK_W-1:0] s_axis_tuser;
    logic                  s_axis_tvalid;
    logic                  s_axis_tready;
    logic [`OQ_DATA_W-1:0] m_axis_tdata;
    logic [`OQ_KEEP_W-1:0] m_axis_tkeep;
    logic                  m_axis_tlast;
    logic [`OQ_RANK_W-1:0] m_axis_tuser;
    logic                  m_axis_tvalid;
    logic                  m_axis_tready;
    logic [`OQ_ADDR_W:0]   free_words;
    logic                  pifo_full;

    logic [31:0]           lfsr;
    // sink mode, 0 held off, 1 always ready, 2 random
    int                    ready_mode;
    // packets of the current test in arrival order
    int                    ph_len [$];
    int                    ph_start [$];
    int                    ph_gap [$];
    logic [`OQ_RANK_W-1:0] ph_rank [$];
    oq_beat_t              ph_beats [$];
    exp_beat_t             exp_q [$];

    oq_top i_dut (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .free_words    (free_words),
        .pifo_full     (pifo_full)
    );

    always #(CLK_NS / 2) axis_aclk = ~axis_aclk;

    ////////////////////////////////////////////////////////////
    // random source, one step per bit
    ////////////////////////////////////////////////////////////

    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out)
            lfsr = lfsr ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %0t ns: %s is %0h, expected %0h",
                               $time, what, got, exp));
    endtask

    ////////////////////////////////////////////////////////////
    // packet model
    ////////////////////////////////////////////////////////////

    function automatic void new_phase();
        ph_len.delete();
        ph_start.delete();
        ph_gap.delete();
        ph_rank.delete();
        ph_beats.delete();
    endfunction

    function automatic void make_packet(input int len, input logic [`OQ_RANK_W-1:0] rank);
        oq_beat_t b;
        ph_start.push_back(ph_beats.size());
        ph_len.push_back(len);
        ph_rank.push_back(rank);
        ph_gap.push_back(int'(rand_bits(2)));
        for (int i = 0; i < len; i++)
        begin
            b.data[`OQ_DATA_W-1:32] = rand_bits(32);
            b.data[31:0]            = rand_bits(32);
            b.keep                  = `OQ_KEEP_W'(rand_bits(`OQ_KEEP_W));
            b.last                  = (i == len - 1);
            ph_beats.push_back(b);
        end
    endfunction

    // stable sort by rank, earliest arrival wins a tie
    function automatic void build_expected();
        bit        taken [$];
        int        best;
        exp_beat_t e;
        foreach (ph_len[p])
            taken.push_back(1'b0);
        for (int n = 0; n < ph_len.size(); n++)
        begin
            best = -1;
            foreach (ph_len[p])
            begin
                if (!taken[p] && (best < 0 || ph_rank[p] < ph_rank[best]))
                    best = p;
            end
            taken[best] = 1'b1;
            for (int b = 0; b < ph_len[best]; b++)
            begin
                e.beat = ph_beats[ph_start[best] + b];
                e.rank = ph_rank[best];
                exp_q.push_back(e);
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic send_packet(input int p);
        int b;
        b = 0;
        repeat (ph_gap[p])
        begin
            @(negedge axis_aclk);
            s_axis_tvalid = 1'b0;
        end
        while (b < ph_len[p])
        begin
            @(negedge axis_aclk);
            s_axis_tvalid = 1'b1;
            s_axis_tdata  = ph_beats[ph_start[p] + b].data;
            s_axis_tkeep  = ph_beats[ph_start[p] + b].keep;
            s_axis_tlast  = ph_beats[ph_start[p] + b].last;
            s_axis_tuser  = ph_rank[p];
            // tready comes from registers, same value at the next rising edge
            if (s_axis_tready)
                b++;
        end
    endtask

    task automatic idle_input();
        @(negedge axis_aclk);
        s_axis_tvalid = 1'b0;
    endtask

    task automatic set_ready(input int mode);
        @(posedge axis_aclk);
        ready_mode = mode;
    endtask

    task automatic drain_and_check();
        while (exp_q.size() != 0)
            @(negedge axis_aclk);
        repeat (4) @(negedge axis_aclk);
        compare_value("free_words after drain", 64'(free_words), 64'd`OQ_WORDS);
        compare_value("pifo_full after drain", 64'(pifo_full), 64'd0);
    endtask

    ////////////////////////////////////////////////////////////
    // sink and output checker
    ////////////////////////////////////////////////////////////

    task automatic check_beat();
        exp_beat_t e;
        if (exp_q.size() == 0)
        begin
            fail_run("an output beat arrived with no packet left in the model");
        end
        else
        begin
            e = exp_q.pop_front();
            compare_value("m_axis_tdata", 64'(m_axis_tdata), 64'(e.beat.data));
            compare_value("m_axis_tkeep", 64'(m_axis_tkeep), 64'(e.beat.keep));
            compare_value("m_axis_tlast", 64'(m_axis_tlast), 64'(e.beat.last));
            compare_value("m_axis_tuser", 64'(m_axis_tuser), 64'(e.rank));
        end
    endtask

    // a beat seen here moves at the next rising edge
    always @(negedge axis_aclk)
    begin
        case (ready_mode)
            2: m_axis_tready = lfsr_bit();
            1: m_axis_tready = 1'b1;
            default: m_axis_tready = 1'b0;
        endcase
        if (axis_resetn && m_axis_tvalid && m_axis_tready)
            check_beat();
    end

    initial
    begin
        #(WATCHDOG_NS);
        fail_run("timeout: the queue did not deliver all packets in time");
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        int                    stored;
        logic [`OQ_RANK_W-1:0] rank;
        lfsr          = 32'h2bca_6f83;
        ready_mode    = 0;
        axis_aclk     = 1'b0;
        axis_resetn   = 1'b0;
        s_axis_tvalid = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tlast  = 1'b0;
        s_axis_tuser  = '0;
        m_axis_tready = 1'b0;

        // reset state
        repeat (4)
        begin
            @(negedge axis_aclk);
            compare_value("m_axis_tvalid in reset", 64'(m_axis_tvalid), 64'd0);
            compare_value("s_axis_tready in reset", 64'(s_axis_tready), 64'd0);
            compare_value("free_words in reset", 64'(free_words), 64'd`OQ_WORDS);
            compare_value("pifo_full in reset", 64'(pifo_full), 64'd0);
        end
        axis_resetn = 1'b1;
        @(negedge axis_aclk);
        compare_value("m_axis_tvalid after reset", 64'(m_axis_tvalid), 64'd0);
        compare_value("free_words after reset", 64'(free_words), 64'd`OQ_WORDS);
        compare_value("pifo_full after reset", 64'(pifo_full), 64'd0);

        // single packet, sink always ready
        new_phase();
        make_packet(1 + int'(rand_bits(8)) % `OQ_MAX_PKT_WORDS,
                    `OQ_RANK_W'(rand_bits(`OQ_RANK_W)));
        build_expected();
        set_ready(1);
        send_packet(0);
        idle_input();
        drain_and_check();

        // rank order behind a long rank 0 plug, sink held off
        // four rank values over six packets, so ties are certain
        set_ready(0);
        new_phase();
        make_packet(`OQ_MAX_PKT_WORDS, '0);
        for (int i = 0; i < BATCH_PKTS; i++)
            make_packet(1 + int'(rand_bits(8)) % `OQ_MAX_PKT_WORDS, `OQ_RANK_W'(rand_bits(2)));
        build_expected();
        for (int p = 0; p < ph_len.size(); p++)
            send_packet(p);
        idle_input();
        repeat (10) @(negedge axis_aclk);
        stored = 0;
        foreach (ph_len[p])
            stored += ph_len[p];
        compare_value("free_words while held", 64'(free_words),
                      64'(`OQ_WORDS - stored + HELD_BEATS));
        set_ready(1);
        drain_and_check();

        // calendar full, the late packet has the highest rank
        set_ready(0);
        new_phase();
        make_packet(`OQ_MAX_PKT_WORDS, '0);
        for (int i = 0; i < `OQ_PIFO_DEPTH; i++)
            make_packet(1 + int'(rand_bits(8)) % 3, `OQ_RANK_W'(rand_bits(3)));
        make_packet(1, '1);
        build_expected();
        for (int p = 0; p <= `OQ_PIFO_DEPTH; p++)
            send_packet(p);
        idle_input();
        repeat (4) @(negedge axis_aclk);
        compare_value("pifo_full with full calendar", 64'(pifo_full), 64'd1);
        fork
            begin
                send_packet(`OQ_PIFO_DEPTH + 1);
                idle_input();
            end
        join_none
        repeat (20)
        begin
            @(negedge axis_aclk);
            compare_value("s_axis_tready with full calendar", 64'(s_axis_tready), 64'd0);
        end
        set_ready(1);
        drain_and_check();

        // random back-pressure while input keeps coming
        new_phase();
        rank = `OQ_RANK_W'(rand_bits(8));
        for (int i = 0; i < STREAM_PKTS; i++)
        begin
            // ranks never fall so arrival order is rank order
            rank = rank + `OQ_RANK_W'(rand_bits(2));
            make_packet(1 + int'(rand_bits(8)) % `OQ_MAX_PKT_WORDS, rank);
        end
        build_expected();
        set_ready(2);
        for (int p = 0; p < ph_len.size(); p++)
            send_packet(p);
        idle_input();
        drain_and_check();

        $display("All tests passed");
        $finish;
    end

endmodule

/* src/oq_top.sv */
`timescale 1ns/1ps
`include "oq_consts.svh"

module oq_top
    import oq_pkg::*;
(
    input  logic                  axis_aclk,
    input  logic                  axis_resetn,
    input  logic [`OQ_DATA_W-1:0] s_axis_tdata,
    input  logic [`OQ_KEEP_W-1:0] s_axis_tkeep,
    input  logic                  s_axis_tlast,
    input  logic [`OQ_RANK_W-1:0] s_axis_tuser,
    input  logic                  s_axis_tvalid,
    output logic                  s_axis_tready,
    output logic [`OQ_DATA_W-1:0] m_axis_tdata,
    output logic [`OQ_KEEP_W-1:0] m_axis_tkeep,
    output logic                  m_axis_tlast,
    output logic [`OQ_RANK_W-1:0] m_axis_tuser,
    output logic                  m_axis_tvalid,
    input  logic                  m_axis_tready,
    output logic [`OQ_ADDR_W:0]   free_words,
    output logic                  pifo_full
);

    // buffer side
    logic                  wr_en;
    oq_beat_t              wr_beat;
    logic                  link_en;
    logic [`OQ_ADDR_W-1:0] link_prev;
    logic [`OQ_ADDR_W-1:0] free_head;
    logic                  rd_en;
    logic [`OQ_ADDR_W-1:0] rd_addr;
    oq_beat_t              rd_beat;
    logic [`OQ_ADDR_W-1:0] rd_next;
    logic                  free_en;
    logic [`OQ_ADDR_W-1:0] free_addr;
    // calendar side
    logic                  ins_en;
    oq_desc_t              ins_desc;
    logic                  pop_en;
    oq_desc_t              top_desc;
    logic                  not_empty;

    oq_enqueue i_enq (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tvalid (s_axis_tvalid),
        .free_head     (free_head),
        .free_count    (free_words),
        .pifo_full     (pifo_full),
        .s_axis_tready (s_axis_tready),
        .wr_en         (wr_en),
        .wr_beat       (wr_beat),
        .link_en       (link_en),
        .link_prev     (link_prev),
        .ins_en        (ins_en),
        .ins_desc      (ins_desc)
    );

    oq_pkt_store i_store (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .wr_en       (wr_en),
        .wr_beat     (wr_beat),
        .link_en     (link_en),
        .link_prev   (link_prev),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .free_en     (free_en),
        .free_addr   (free_addr),
        .free_head   (free_head),
        .free_count  (free_words),
        .rd_beat     (rd_beat),
        .rd_next     (rd_next)
    );

    oq_pifo_calendar i_cal (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .ins_en      (ins_en),
        .ins_desc    (ins_desc),
        .pop_en      (pop_en),
        .top_desc    (top_desc),
        .not_empty   (not_empty),
        .full        (pifo_full)
    );

    oq_dequeue i_deq (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .top_desc      (top_desc),
        .not_empty     (not_empty),
        .rd_beat       (rd_beat),
        .rd_next       (rd_next),
        .m_axis_tready (m_axis_tready),
        .pop_en        (pop_en),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .free_en       (free_en),
        .free_addr     (free_addr),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tvalid (m_axis_tvalid)
    );

endmodule

/* src/oq_dequeue.sv */
`timescale 1ns/1ps
`include "oq_consts.svh"

module oq_dequeue
    import oq_pkg::*;
(
    input  logic                  axis_aclk,
    input  logic                  axis_resetn,
    input  oq_desc_t              top_desc,
    input  logic                  not_empty,
    input  oq_beat_t              rd_beat,
    input  logic [`OQ_ADDR_W-1:0] rd_next,
    input  logic                  m_axis_tready,
    output logic                  pop_en,
    output logic                  rd_en,
    output logic [`OQ_ADDR_W-1:0] rd_addr,
    output logic                  free_en,
    output logic [`OQ_ADDR_W-1:0] free_addr,
    output logic [`OQ_DATA_W-1:0] m_axis_tdata,
    output logic [`OQ_KEEP_W-1:0] m_axis_tkeep,
    output logic                  m_axis_tlast,
    output logic [`OQ_RANK_W-1:0] m_axis_tuser,
    output logic                  m_axis_tvalid
);

    // chain walk
    logic                  busy;
    logic                  have_addr;
    logic [`OQ_ADDR_W-1:0] cur_addr;
    logic [`OQ_RANK_W-1:0] cur_rank;
    // read stage
    logic                  rd_vld;
    logic [`OQ_ADDR_W-1:0] rd_addr_q;
    logic [`OQ_RANK_W-1:0] rd_rank;
    logic                  chain_more;
    logic                  chain_end;
    // output register and skid
    logic                  out_vld;
    oq_beat_t              out_beat;
    logic [`OQ_RANK_W-1:0] out_rank;
    logic                  skid_vld;
    oq_beat_t              skid_beat;
    logic [`OQ_RANK_W-1:0] skid_rank;
    logic                  take;
    logic [2:0]            fill;

    assign chain_more = rd_vld && !rd_beat.last;
    assign chain_end  = rd_vld && rd_beat.last;
    assign take       = out_vld && m_axis_tready;

    // beats held after this cycle, a new read needs one spare place
    assign fill = 3'(out_vld) + 3'(skid_vld) + 3'(rd_vld) - 3'(take);

    // next packet may be popped while the last word is still on its way out
    assign pop_en  = not_empty && (!busy || chain_end);
    assign rd_en   = (have_addr || chain_more) && (fill <= 3'd1);
    assign rd_addr = have_addr ? cur_addr : rd_next;

    // word goes back as soon as its contents are out of the memory
    assign free_en   = rd_vld;
    assign free_addr = rd_addr_q;

    assign m_axis_tvalid = out_vld;
    assign m_axis_tdata  = out_beat.data;
    assign m_axis_tkeep  = out_beat.keep;
    assign m_axis_tlast  = out_beat.last;
    assign m_axis_tuser  = out_rank;

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            busy      <= 1'b0;
            have_addr <= 1'b0;
            rd_vld    <= 1'b0;
            out_vld   <= 1'b0;
            skid_vld  <= 1'b0;
        end
        else
        begin
            if (pop_en)
                busy <= 1'b1;
            else if (chain_end)
                busy <= 1'b0;
            // park the next address when the read has to wait
            if (pop_en)
                have_addr <= 1'b1;
            else if (rd_en)
                have_addr <= 1'b0;
            else if (chain_more)
                have_addr <= 1'b1;
            rd_vld <= rd_en;
            if (!out_vld || take)
            begin
                out_vld  <= skid_vld || rd_vld;
                skid_vld <= skid_vld && rd_vld;
            end
            else
            begin
                skid_vld <= skid_vld || rd_vld;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // payload
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (pop_en)
        begin
            cur_addr <= top_desc.head;
            cur_rank <= top_desc.rank;
        end
        else if (chain_more && !rd_en)
        begin
            cur_addr <= rd_next;
        end
        if (rd_en)
        begin
            rd_addr_q <= rd_addr;
            rd_rank   <= cur_rank;
        end
        // skid drains first to keep beat order
        if (!out_vld || take)
        begin
            out_beat <= skid_vld ? skid_beat : rd_beat;
            out_rank <= skid_vld ? skid_rank : rd_rank;
        end
        if (rd_vld && out_vld && (skid_vld || !take))
        begin
            skid_beat <= rd_beat;
            skid_rank <= rd_rank;
        end
    end

endmodule

/* src/oq_pifo_calendar.sv */
`timescale 1ns/1ps
`include "oq_consts.svh"

module oq_pifo_calendar
    import oq_pkg::*;
(
    input  logic     axis_aclk,
    input  logic     axis_resetn,
    input  logic     ins_en,
    input  oq_desc_t ins_desc,
    input  logic     pop_en,
    output oq_desc_t top_desc,
    output logic     not_empty,
    output logic     full
);

    localparam int DEPTH = `OQ_PIFO_DEPTH;
    localparam int IDX_W = `OQ_PIFO_IDX_W;

    // slot 0 holds the lowest rank
    oq_desc_t         slot     [DEPTH];
    oq_desc_t         slot_nxt [DEPTH];
    oq_desc_t         ext      [DEPTH+1];
    logic [DEPTH:0]   stay;
    logic [IDX_W-1:0] count;

    assign top_desc  = slot[0];
    assign not_empty = (count != '0);
    assign full      = (count == IDX_W'(DEPTH));

    // valid entries that stay ahead of the new one, a prefix of the array
    always_comb
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            ext[i]  = slot[i];
            stay[i] = (i < int'(count)) && (slot[i].rank <= ins_desc.rank);
        end
        ext[DEPTH]  = '0;
        stay[DEPTH] = 1'b0;
    end

    ////////////////////////////////////////////////////////////
    // shift toward the top on pop, open a gap on insert
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        oq_desc_t cur;
        oq_desc_t prv;
        logic     cur_stay;
        logic     prv_stay;

        for (int i = 0; i < DEPTH; i++)
        begin
            if (pop_en)
            begin
                cur      = ext[i + 1];
                cur_stay = stay[i + 1];
                prv      = ext[i];
                prv_stay = (i == 0) || stay[i];
            end
            else
            begin
                cur      = ext[i];
                cur_stay = stay[i];
                prv      = ext[(i == 0) ? 0 : i - 1];
                prv_stay = (i == 0) || stay[(i == 0) ? 0 : i - 1];
            end
            // first slot past the stayers takes the insert
            if (ins_en && !cur_stay)
            begin
                slot_nxt[i] = prv_stay ? ins_desc : prv;
            end
            else
            begin
                slot_nxt[i] = cur;
            end
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        slot <= slot_nxt;
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            count <= '0;
        end
        else
        begin
            count <= count + IDX_W'(ins_en) - IDX_W'(pop_en);
        end
    end

endmodule

/* src/oq_enqueue.sv */
`timescale 1ns/1ps
`include "oq_consts.svh"

module oq_enqueue
    import oq_pkg::*;
(
    input  logic                  axis_aclk,
    input  logic                  axis_resetn,
    input  logic [`OQ_DATA_W-1:0] s_axis_tdata,
    input  logic [`OQ_KEEP_W-1:0] s_axis_tkeep,
    input  logic                  s_axis_tlast,
    input  logic [`OQ_RANK_W-1:0] s_axis_tuser,
    input  logic                  s_axis_tvalid,
    input  logic [`OQ_ADDR_W-1:0] free_head,
    input  logic [`OQ_ADDR_W:0]   free_count,
    input  logic                  pifo_full,
    output logic                  s_axis_tready,
    output logic                  wr_en,
    output oq_beat_t              wr_beat,
    output logic                  link_en,
    output logic [`OQ_ADDR_W-1:0] link_prev,
    output logic                  ins_en,
    output oq_desc_t              ins_desc
);

    typedef enum logic [1:0] {
        ST_OFF,
        ST_IDLE,
        ST_BODY
    } enq_state_t;

    enq_state_t            state;
    logic                  accept;
    logic                  first_beat;
    logic [`OQ_RANK_W-1:0] pkt_rank;
    logic [`OQ_ADDR_W-1:0] pkt_head;
    logic [`OQ_ADDR_W-1:0] prev_word;

    // admission on the first beat only, the reserve covers the rest
    always_comb
    begin
        case (state)
            ST_IDLE: s_axis_tready = (free_count >= `OQ_MAX_PKT_WORDS) && !pifo_full;
            ST_BODY: s_axis_tready = 1'b1;
            default: s_axis_tready = 1'b0;
        endcase
    end

    assign accept     = s_axis_tvalid && s_axis_tready;
    assign first_beat = (state == ST_IDLE);

    // beat goes straight into the free-list head
    assign wr_en        = accept;
    assign wr_beat.data = s_axis_tdata;
    assign wr_beat.keep = s_axis_tkeep;
    assign wr_beat.last = s_axis_tlast;

    assign link_en   = accept && !first_beat;
    assign link_prev = prev_word;

    // descriptor leaves with the last beat
    assign ins_en        = accept && s_axis_tlast;
    assign ins_desc.rank = first_beat ? s_axis_tuser : pkt_rank;
    assign ins_desc.head = first_beat ? free_head : pkt_head;

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state <= ST_OFF;
        end
        else if (state == ST_OFF)
        begin
            state <= ST_IDLE;
        end
        else if (accept)
        begin
            state <= s_axis_tlast ? ST_IDLE : ST_BODY;
        end
    end

    // packet context
    always_ff @(posedge axis_aclk)
    begin
        if (accept)
        begin
            prev_word <= free_head;
            if (first_beat)
            begin
                pkt_rank <= s_axis_tuser;
                pkt_head <= free_head;
            end
        end
    end

endmodule

/* src/oq_pkt_store.sv */
`timescale 1ns/1ps
`include "oq_consts.svh"

module oq_pkt_store
    import oq_pkg::*;
(
    input  logic                  axis_aclk,
    input  logic                  axis_resetn,
    input  logic                  wr_en,
    input  oq_beat_t              wr_beat,
    input  logic                  link_en,
    input  logic [`OQ_ADDR_W-1:0] link_prev,
    input  logic                  rd_en,
    input  logic [`OQ_ADDR_W-1:0] rd_addr,
    input  logic                  free_en,
    input  logic [`OQ_ADDR_W-1:0] free_addr,
    output logic [`OQ_ADDR_W-1:0] free_head,
    output logic [`OQ_ADDR_W:0]   free_count,
    output oq_beat_t              rd_beat,
    output logic [`OQ_ADDR_W-1:0] rd_next
);

    localparam int CNT_W = `OQ_ADDR_W + 1;

    oq_beat_t              beat_mem [`OQ_WORDS];
    // packet chains and the free list share one pointer table
    logic [`OQ_ADDR_W-1:0] next_tbl [`OQ_WORDS];
    logic [`OQ_ADDR_W-1:0] fl_head;
    logic [`OQ_ADDR_W-1:0] fl_tail;
    logic [CNT_W-1:0]      fl_count;
    logic                  fl_drained;

    assign free_head  = fl_head;
    assign free_count = fl_count;

    // no free word left once this cycle's allocate is done
    assign fl_drained = (fl_count == '0) || ((fl_count == CNT_W'(1)) && wr_en);

    ////////////////////////////////////////////////////////////
    // beat memory, one cycle read
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (wr_en)
        begin
            beat_mem[fl_head] <= wr_beat;
        end
        if (rd_en)
        begin
            rd_beat <= beat_mem[rd_addr];
            rd_next <= next_tbl[rd_addr];
        end
    end

    ////////////////////////////////////////////////////////////
    // next pointers and free list
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            // every word chained in address order
            for (int i = 0; i < `OQ_WORDS; i++)
            begin
                next_tbl[i] <= `OQ_ADDR_W'(i + 1);
            end
            fl_head  <= '0;
            fl_tail  <= `OQ_ADDR_W'(`OQ_WORDS - 1);
            fl_count <= CNT_W'(`OQ_WORDS);
        end
        else
        begin
            // hook the new word behind the previous beat of its packet
            if (wr_en && link_en)
            begin
                next_tbl[link_prev] <= fl_head;
            end
            // returned words go to the tail
            if (free_en)
            begin
                fl_tail <= free_addr;
                if (!fl_drained)
                begin
                    next_tbl[fl_tail] <= free_addr;
                end
            end
            // an empty list restarts at the returned word
            if (free_en && fl_drained)
            begin
                fl_head <= free_addr;
            end
            else if (wr_en)
            begin
                fl_head <= next_tbl[fl_head];
            end
            fl_count <= fl_count + CNT_W'(free_en) - CNT_W'(wr_en);
        end
    end

endmodule

/* src/oq_pkg.sv */
`include "oq_consts.svh"

package oq_pkg;

    ////////////////////////////////////////////////////////////
    // buffered beat
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`OQ_DATA_W-1:0] data;
        logic [`OQ_KEEP_W-1:0] keep;
        logic                  last;
    } oq_beat_t;

    ////////////////////////////////////////////////////////////
    // calendar descriptor
    ////////////////////////////////////////////////////////////

    // lower rank leaves first
    typedef struct packed {
        logic [`OQ_RANK_W-1:0] rank;
        logic [`OQ_ADDR_W-1:0] head;
    } oq_desc_t;

endpackage

/* src/oq_consts.svh */
`ifndef OQ_CONSTS_SVH
`define OQ_CONSTS_SVH

// stream beat layout
`define OQ_DATA_W 64
`define OQ_KEEP_W 8
`define OQ_RANK_W 16

// shared word buffer
`define OQ_WORDS 64
`define OQ_ADDR_W 6

// rank calendar
`define OQ_PIFO_DEPTH 16
// holds 0 to OQ_PIFO_DEPTH
`define OQ_PIFO_IDX_W 5

// longest packet in beats, also the free-word reserve at admission
`define OQ_MAX_PKT_WORDS 8

`endif
